// File: include/div_macros.svh
`ifndef DIV_MACROS_SVH
`define DIV_MACROS_SVH

// operand and result width of the divide unit.
// the word opcodes narrow to the low half, so this stays at 64.
`define DIV_XLEN 64

// entries in the request queue between decoder and divider.
// must be a power of two so the pointers wrap on their own.
`define DIV_FIFO_DEPTH 4

`endif

// File: src/div_pkg.sv
package div_pkg;

	// the eight M-extension division opcodes.
	// bit 2 selects the word forms and bit 1 selects the remainder.
	typedef enum logic [2:0] {
		OP_DIV   = 3'd0,
		OP_DIVU  = 3'd1,
		OP_REM   = 3'd2,
		OP_REMU  = 3'd3,
		OP_DIVW  = 3'd4,
		OP_DIVUW = 3'd5,
		OP_REMW  = 3'd6,
		OP_REMUW = 3'd7
	} div_op_e;

	// divider FSM states.
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0, // waiting for a job at the queue head.
		ST_RUN  = 2'd1, // one restoring step per cycle.
		ST_DONE = 2'd2  // result formed and offered downstream.
	} div_state_e;

endpackage

// File: src/div_req_decode.sv
`timescale 1ns/1ps
`include "div_macros.svh"

module div_req_decode (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 flush,
	input  logic                 req_valid,
	output logic                 req_ready,
	input  div_pkg::div_op_e     req_op,
	input  logic [`DIV_XLEN-1:0] req_a,
	input  logic [`DIV_XLEN-1:0] req_b,
	output logic                 dec_valid,
	input  logic                 dec_ready,
	output logic [`DIV_XLEN-1:0] dec_mag_a,
	output logic [`DIV_XLEN-1:0] dec_mag_b,
	output logic                 dec_neg_quot,
	output logic                 dec_neg_rem,
	output logic                 dec_word,
	output logic                 dec_want_rem
);
	import div_pkg::*;

	localparam int XLEN = `DIV_XLEN;
	localparam int HALF = XLEN / 2;

	logic            op_signed;
	logic            op_word;
	logic            op_rem;
	logic [XLEN-1:0] a_ext;
	logic [XLEN-1:0] b_ext;
	logic            a_neg;
	logic            b_neg;
	logic            b_zero;
	logic [XLEN-1:0] mag_a;
	logic [XLEN-1:0] mag_b;
	logic            accept;

	always_comb begin
		op_signed = 1'b0;
		op_word   = 1'b0;
		op_rem    = 1'b0;
		case (req_op)
			OP_DIV:   op_signed = 1'b1;
			OP_DIVU:  op_signed = 1'b0;
			OP_REM:   {op_signed, op_rem} = 2'b11;
			OP_REMU:  op_rem = 1'b1;
			OP_DIVW:  {op_signed, op_word} = 2'b11;
			OP_DIVUW: op_word = 1'b1;
			OP_REMW:  {op_signed, op_word, op_rem} = 3'b111;
			OP_REMUW: {op_word, op_rem} = 2'b11;
			default:  op_signed = 1'b0; // unknown opcode decodes as an unsigned divide.
		endcase
	end

	// word forms only look at the low half of each operand.
	assign a_ext = !op_word ? req_a :
		op_signed ? {{HALF{req_a[HALF-1]}}, req_a[HALF-1:0]} : {{HALF{1'b0}}, req_a[HALF-1:0]};
	assign b_ext = !op_word ? req_b :
		op_signed ? {{HALF{req_b[HALF-1]}}, req_b[HALF-1:0]} : {{HALF{1'b0}}, req_b[HALF-1:0]};

	assign a_neg  = op_signed && a_ext[XLEN-1];
	assign b_neg  = op_signed && b_ext[XLEN-1];
	assign b_zero = (b_ext == '0);
	assign mag_a  = a_neg ? -a_ext : a_ext;
	assign mag_b  = b_neg ? -b_ext : b_ext;

	// the register takes a new request when empty or when it drains this cycle.
	assign req_ready = !dec_valid || dec_ready;
	assign accept    = req_valid && req_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
		end else if (flush) begin
			dec_valid <= 1'b0;
		end else if (accept) begin
			dec_valid <= 1'b1;
		end else if (dec_ready) begin
			dec_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			dec_mag_a    <= mag_a;
			dec_mag_b    <= mag_b;
			dec_neg_quot <= (a_neg ^ b_neg) && !b_zero; // a zero divisor leaves the quotient all ones.
			dec_neg_rem  <= a_neg;                      // remainder takes the sign of the dividend.
			dec_word     <= op_word;
			dec_want_rem <= op_rem;
		end
	end

	// a stalled job must not change under the queue.
	assert property (@(posedge clk) disable iff (!rst_n || flush)
		dec_valid && !dec_ready |=> dec_valid && $stable({dec_mag_a, dec_mag_b,
			dec_neg_quot, dec_neg_rem, dec_word, dec_want_rem}));

endmodule

// File: src/div_req_fifo.sv
`timescale 1ns/1ps
`include "div_macros.svh"

module div_req_fifo (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 flush,
	input  logic                 dec_valid,
	output logic                 dec_ready,
	input  logic [`DIV_XLEN-1:0] dec_mag_a,
	input  logic [`DIV_XLEN-1:0] dec_mag_b,
	input  logic                 dec_neg_quot,
	input  logic                 dec_neg_rem,
	input  logic                 dec_word,
	input  logic                 dec_want_rem,
	output logic                 job_valid,
	input  logic                 job_pop,
	output logic [`DIV_XLEN-1:0] job_mag_a,
	output logic [`DIV_XLEN-1:0] job_mag_b,
	output logic                 job_neg_quot,
	output logic                 job_neg_rem,
	output logic                 job_word,
	output logic                 job_want_rem
);

	localparam int XLEN  = `DIV_XLEN;
	localparam int DEPTH = `DIV_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int ENT_W = 2 * XLEN + 4;

	// one entry holds both magnitudes and the four flags.
	logic [ENT_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             push;
	logic [ENT_W-1:0] head;

	assign dec_ready = (count != (PTR_W+1)'(DEPTH));
	assign job_valid = (count != '0);
	assign push      = dec_valid && dec_ready;

	// show-ahead, the head entry is always on the outputs.
	assign head = mem[rd_ptr];
	assign {job_mag_a, job_mag_b, job_neg_quot, job_neg_rem, job_word, job_want_rem} = head;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= {dec_mag_a, dec_mag_b, dec_neg_quot, dec_neg_rem, dec_word,
				dec_want_rem};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // wraps since depth is a power of two.
			if (job_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(job_pop);
		end
	end

	// the divider only takes a job that is actually there.
	assert property (@(posedge clk) disable iff (!rst_n) job_pop |-> job_valid);

endmodule

// File: src/div_core.sv
`timescale 1ns/1ps
`include "div_macros.svh"

module div_core (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 flush,
	input  logic                 job_valid,
	output logic                 job_pop,
	input  logic [`DIV_XLEN-1:0] job_mag_a,
	input  logic [`DIV_XLEN-1:0] job_mag_b,
	input  logic                 job_neg_quot,
	input  logic                 job_neg_rem,
	input  logic                 job_word,
	input  logic                 job_want_rem,
	output logic                 result_valid,
	input  logic                 result_ready,
	output logic [`DIV_XLEN-1:0] result
);
	import div_pkg::*;

	localparam int XLEN  = `DIV_XLEN;
	localparam int HALF  = XLEN / 2;
	localparam int CNT_W = $clog2(XLEN) + 1;

	div_state_e        state;
	logic [CNT_W-1:0]  step_cnt;
	logic [2*XLEN-1:0] rem_div;  // partial remainder on top, dividend bits below.
	logic [XLEN-1:0]   divisor;
	logic [XLEN-1:0]   quot;
	logic              neg_quot;
	logic              neg_rem;
	logic              word;
	logic              want_rem;
	logic [XLEN:0]     diff;
	logic [XLEN-1:0]   sel;
	logic [XLEN-1:0]   fixed;
	logic [XLEN-1:0]   res_next;

	// trial subtraction on the top 65 bits, bit XLEN set means the divisor did not fit.
	assign diff = rem_div[2*XLEN-1:XLEN-1] - {1'b0, divisor};

	assign job_pop = (state == ST_IDLE) && job_valid;

	always_comb begin
		sel      = want_rem ? rem_div[2*XLEN-1:XLEN] : quot;
		fixed    = (want_rem ? neg_rem : neg_quot) ? -sel : sel;
		res_next = word ? {{HALF{fixed[HALF-1]}}, fixed[HALF-1:0]} : fixed;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= ST_IDLE;
			step_cnt     <= '0;
			result_valid <= 1'b0;
		end else if (flush) begin
			state        <= ST_IDLE;
			step_cnt     <= '0;
			result_valid <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (job_valid) begin
						state    <= ST_RUN;
						step_cnt <= job_word ? CNT_W'(HALF) : CNT_W'(XLEN);
					end
				end
				ST_RUN: begin
					step_cnt <= step_cnt - 1'b1;
					if (step_cnt == CNT_W'(1))
						state <= ST_DONE;
				end
				ST_DONE: begin
					// first cycle here loads the result register, then it waits for the consumer.
					if (!result_valid) begin
						result_valid <= 1'b1;
					end else if (result_ready) begin
						result_valid <= 1'b0;
						state        <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (job_pop) begin
			// word dividends start in the upper half so that 32 steps consume them.
			rem_div  <= job_word ? {{HALF{1'b0}}, job_mag_a, {HALF{1'b0}}}
				: {{XLEN{1'b0}}, job_mag_a};
			divisor  <= job_mag_b;
			quot     <= '0;
			neg_quot <= job_neg_quot;
			neg_rem  <= job_neg_rem;
			word     <= job_word;
			want_rem <= job_want_rem;
		end else if (state == ST_RUN) begin
			if (diff[XLEN])
				rem_div <= {rem_div[2*XLEN-2:0], 1'b0}; // restore, just shift.
			else
				rem_div <= {diff[XLEN-1:0], rem_div[XLEN-2:0], 1'b0};
			quot <= {quot[XLEN-2:0], ~diff[XLEN]};
		end
		if ((state == ST_DONE) && !result_valid)
			result <= res_next;
	end

	// the result must hold while the consumer stalls.
	assert property (@(posedge clk) disable iff (!rst_n || flush)
		result_valid && !result_ready |=> result_valid && $stable(result));

endmodule

// File: src/div_unit.sv
`timescale 1ns/1ps
`include "div_macros.svh"

module div_unit (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 flush,
	input  logic                 req_valid,
	output logic                 req_ready,
	input  div_pkg::div_op_e     req_op,
	input  logic [`DIV_XLEN-1:0] req_a,
	input  logic [`DIV_XLEN-1:0] req_b,
	output logic                 result_valid,
	input  logic                 result_ready,
	output logic [`DIV_XLEN-1:0] result
);

	// decoder register to queue.
	logic                 dec_valid;
	logic                 dec_ready;
	logic [`DIV_XLEN-1:0] dec_mag_a;
	logic [`DIV_XLEN-1:0] dec_mag_b;
	logic                 dec_neg_quot;
	logic                 dec_neg_rem;
	logic                 dec_word;
	logic                 dec_want_rem;

	// queue head to divider.
	logic                 job_valid;
	logic                 job_pop;
	logic [`DIV_XLEN-1:0] job_mag_a;
	logic [`DIV_XLEN-1:0] job_mag_b;
	logic                 job_neg_quot;
	logic                 job_neg_rem;
	logic                 job_word;
	logic                 job_want_rem;

	div_req_decode div_req_decode_i (
		.clk, .rst_n, .flush,
		.req_valid, .req_ready, .req_op, .req_a, .req_b,
		.dec_valid, .dec_ready, .dec_mag_a, .dec_mag_b,
		.dec_neg_quot, .dec_neg_rem, .dec_word, .dec_want_rem
	);

	div_req_fifo div_req_fifo_i (
		.clk, .rst_n, .flush,
		.dec_valid, .dec_ready, .dec_mag_a, .dec_mag_b,
		.dec_neg_quot, .dec_neg_rem, .dec_word, .dec_want_rem,
		.job_valid, .job_pop, .job_mag_a, .job_mag_b,
		.job_neg_quot, .job_neg_rem, .job_word, .job_want_rem
	);

	div_core div_core_i (
		.clk, .rst_n, .flush,
		.job_valid, .job_pop, .job_mag_a, .job_mag_b,
		.job_neg_quot, .job_neg_rem, .job_word, .job_want_rem,
		.result_valid, .result_ready, .result
	);

endmodule

// File: verification/div_clk_gen.sv
`timescale 1ns/1ps

module div_clk_gen #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// reset leaves on a rising edge so the first active cycle is a whole one.
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// File: verification/div_unit_tb.sv
`timescale 1ns/1ps
`include "div_macros.svh"

module div_unit_tb;
	import div_pkg::*;

	localparam int XLEN          = `DIV_XLEN;
	localparam int WAIT_LIMIT    = 2000;
	localparam int RELEASE_AFTER = 300; // stall length that means the unit is full.

	logic            clk;
	logic            rst_n;
	logic            flush;
	logic            req_valid;
	logic            req_ready;
	div_op_e         req_op;
	logic [XLEN-1:0] req_a;
	logic [XLEN-1:0] req_b;
	logic            result_valid;
	logic            result_ready;
	logic [XLEN-1:0] result;

	logic [XLEN-1:0] exp_q[$]; // expected results in request order.
	logic [XLEN-1:0] mon_exp;
	logic [31:0]     rng;
	logic            saw_stall;
	int              err_count;
	int              test_errs;
	int              tests_passed;
	int              tests_failed;
	string           test_name;

	div_clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

	div_unit div_unit_i (
		.clk, .rst_n, .flush,
		.req_valid, .req_ready, .req_op, .req_a, .req_b,
		.result_valid, .result_ready, .result
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// RISC-V M rules with the zero divisor and overflow results written out.
	function automatic logic [XLEN-1:0] ref_div(input div_op_e op, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b);
		logic               is_signed;
		logic               is_word;
		logic               is_rem;
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic signed [31:0] wa;
		logic signed [31:0] wb;
		logic [63:0]        q;
		logic [63:0]        r;
		logic [31:0]        wq;
		logic [31:0]        wr;
		logic [31:0]        wsel;
		case (op)
			OP_DIV:   {is_signed, is_word, is_rem} = 3'b100;
			OP_DIVU:  {is_signed, is_word, is_rem} = 3'b000;
			OP_REM:   {is_signed, is_word, is_rem} = 3'b101;
			OP_REMU:  {is_signed, is_word, is_rem} = 3'b001;
			OP_DIVW:  {is_signed, is_word, is_rem} = 3'b110;
			OP_DIVUW: {is_signed, is_word, is_rem} = 3'b010;
			OP_REMW:  {is_signed, is_word, is_rem} = 3'b111;
			default:  {is_signed, is_word, is_rem} = 3'b011;
		endcase
		sa = a;
		sb = b;
		wa = a[31:0];
		wb = b[31:0];
		if (b == '0) begin
			q = '1;
			r = a;
		end else if (is_signed && a == 64'h8000000000000000 && b == '1) begin
			q = a;
			r = '0;
		end else if (is_signed) begin
			q = sa / sb;
			r = sa % sb;
		end else begin
			q = a / b;
			r = a % b;
		end
		if (wb == 0) begin
			wq = '1;
			wr = a[31:0];
		end else if (is_signed && wa == 32'h80000000 && wb == '1) begin
			wq = a[31:0];
			wr = '0;
		end else if (is_signed) begin
			wq = wa / wb;
			wr = wa % wb;
		end else begin
			wq = a[31:0] / b[31:0];
			wr = a[31:0] % b[31:0];
		end
		wsel = is_rem ? wr : wq;
		if (is_word)
			return {{32{wsel[31]}}, wsel};
		return is_rem ? r : q;
	endfunction

	task automatic abort_run(input string why);
		$display("%0t: %s", $time, why);
		$display("Testbench failed");
		$finish;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = err_count;
	endtask

	task automatic finish_test();
		if (err_count == test_errs) begin
			tests_passed++;
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, err_count - test_errs);
		end
	endtask

	// offers one request and returns on the edge where it transfers.
	task automatic send(input div_op_e op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
			input logic [XLEN-1:0] expected);
		int waited;
		waited = 0;
		req_valid <= 1'b1;
		req_op    <= op;
		req_a     <= a;
		req_b     <= b;
		@(posedge clk);
		while (!req_ready && waited < WAIT_LIMIT) begin
			saw_stall = 1'b1;
			waited++;
			if (waited == RELEASE_AFTER && !result_ready)
				result_ready <= 1'b1; // let the held results drain.
			@(posedge clk);
		end
		if (waited >= WAIT_LIMIT)
			abort_run("timed out waiting for req_ready");
		else
			exp_q.push_back(expected);
	endtask

	task automatic send_random();
		div_op_e         op;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		rng = xorshift32(rng);
		op  = div_op_e'(rng[2:0]);
		a   = {rng, xorshift32(rng)};
		rng = xorshift32(xorshift32(rng));
		b   = {xorshift32(rng), rng};
		case (rng[6:4])
			3'd0: b = '0;
			3'd1: b = '1;
			3'd2: b = {56'b0, rng[15:8]};
			3'd3: begin
				a = 64'h8000000080000000; // the most negative word overflows the word forms.
				b = '1;
			end
			default: ;
		endcase
		rng = xorshift32(rng);
		send(op, a, b, ref_div(op, a, b));
	endtask

	task automatic wait_drain();
		int idle;
		int last;
		idle = 0;
		last = exp_q.size();
		while (exp_q.size() != 0 && idle < WAIT_LIMIT) begin
			@(posedge clk);
			if (exp_q.size() != last) begin
				last = exp_q.size();
				idle = 0;
			end else begin
				idle++;
			end
		end
		if (exp_q.size() != 0)
			abort_run("timed out waiting for result_valid");
	endtask

	always @(posedge clk) begin
		if (rst_n && result_valid && result_ready) begin
			if (exp_q.size() == 0) begin
				$display("%0t: a result came out with no request outstanding", $time);
				err_count++;
			end else begin
				mon_exp = exp_q.pop_front();
				if (result !== mon_exp) begin
					$display("ERR %0t result expected %h got %h", $time, mon_exp, result);
					err_count++;
				end
			end
		end
	end

	initial begin
		int              fd;
		int              code;
		int              c;
		int              lines;
		int              cases;
		int              waited;
		logic [2:0]      f_op;
		logic [XLEN-1:0] f_a;
		logic [XLEN-1:0] f_b;
		logic [XLEN-1:0] f_exp;
		req_valid    <= 1'b0;
		req_op       <= OP_DIV;
		req_a        <= '0;
		req_b        <= '0;
		flush        <= 1'b0;
		result_ready <= 1'b1;
		rng          = 32'h8e95;
		err_count    = 0;
		tests_passed = 0;
		tests_failed = 0;
		waited       = 0;
		while (rst_n !== 1'b1 && waited < WAIT_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (rst_n !== 1'b1)
			abort_run("reset was never released");
		@(posedge clk);
		start_test("reset state");
		if (req_ready !== 1'b1) begin
			$display("ERR %0t req_ready expected 1 got %b", $time, req_ready);
			err_count++;
		end
		if (result_valid !== 1'b0) begin
			$display("ERR %0t result_valid expected 0 got %b", $time, result_valid);
			err_count++;
		end
		finish_test();

		start_test("directed cases");
		fd = $fopen("verification/div_cases.txt", "r");
		if (fd == 0)
			abort_run("could not open verification/div_cases.txt");
		lines = 0;
		cases = 0;
		while (!$feof(fd) && lines < 1000) begin
			lines++;
			code = $fscanf(fd, "%h %h %h %h\n", f_op, f_a, f_b, f_exp);
			if (code == 4) begin
				send(div_op_e'(f_op), f_a, f_b, f_exp);
				cases++;
			end else begin
				c = $fgetc(fd); // skip the rest of a comment line.
				while (c != "\n" && c != -1)
					c = $fgetc(fd);
			end
		end
		$fclose(fd);
		req_valid <= 1'b0;
		wait_drain();
		if (cases == 0) begin
			$display("no cases were read from the case file");
			err_count++;
		end
		finish_test();

		start_test("divide by zero");
		send(OP_DIV, 64'h0123456789abcdef, 64'h0, '1);
		send(OP_DIVU, 64'hfedcba9876543210, 64'h0, '1);
		send(OP_REM, 64'hfedcba9876543210, 64'h0, 64'hfedcba9876543210);
		send(OP_REMU, 64'hfedcba9876543210, 64'h0, 64'hfedcba9876543210);
		send(OP_DIVW, 64'h0123456789abcdef, 64'hffffffff00000000, '1);
		send(OP_DIVUW, 64'h0123456789abcdef, 64'hffffffff00000000, '1);
		send(OP_REMW, 64'h0123456789abcdef, 64'hffffffff00000000, 64'hffffffff89abcdef);
		send(OP_REMUW, 64'hfedcba9801234567, 64'h0000000100000000, 64'h0000000001234567);
		req_valid <= 1'b0;
		wait_drain();
		finish_test();

		start_test("signed overflow");
		send(OP_DIV, 64'h8000000000000000, '1, 64'h8000000000000000);
		send(OP_REM, 64'h8000000000000000, '1, 64'h0);
		send(OP_DIVW, 64'h0000000080000000, 64'h00000000ffffffff, 64'hffffffff80000000);
		send(OP_REMW, 64'h0000000080000000, 64'h00000000ffffffff, 64'h0);
		req_valid <= 1'b0;
		wait_drain();
		finish_test();

		start_test("random back to back");
		repeat (200) send_random();
		req_valid <= 1'b0;
		wait_drain();
		finish_test();

		start_test("back-pressure");
		saw_stall = 1'b0;
		result_ready <= 1'b0;
		repeat (`DIV_FIFO_DEPTH + 3) send_random();
		req_valid    <= 1'b0;
		result_ready <= 1'b1;
		wait_drain();
		if (!saw_stall) begin
			$display("req_ready never fell while results were held back");
			err_count++;
		end
		finish_test();

		start_test("flush");
		result_ready <= 1'b0;
		send(OP_DIV, 64'h0000000000000064, 64'h0000000000000007, 64'h000000000000000e);
		send(OP_REMU, 64'h0000000000000064, 64'h0000000000000007, 64'h0000000000000002);
		send(OP_DIVW, 64'h0000000000000064, 64'h0000000000000005, 64'h0000000000000014);
		send(OP_REM, 64'hffffffffffffff9c, 64'h0000000000000007, 64'hfffffffffffffffe);
		send(OP_DIVU, 64'h0000000000000064, 64'h0000000000000003, 64'h0000000000000021);
		send(OP_REMW, 64'h0000000000000064, 64'h0000000000000003, 64'h0000000000000001);
		req_valid <= 1'b0;
		repeat (10) @(posedge clk); // first job is mid-run in the divider now.
		if (req_ready !== 1'b0) begin
			$display("ERR %0t req_ready expected 0 got %b", $time, req_ready);
			err_count++;
		end
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		result_ready <= 1'b1;
		exp_q.delete();
		repeat (100) begin
			@(posedge clk);
			if (result_valid !== 1'b0) begin
				$display("ERR %0t result_valid expected 0 got %b", $time, result_valid);
				err_count++;
			end
			if (req_ready !== 1'b1) begin
				$display("ERR %0t req_ready expected 1 got %b", $time, req_ready);
				err_count++;
			end
		end
		send(OP_DIVW, 64'hffffffffffffffec, 64'h0000000000000006, 64'hfffffffffffffffd);
		req_valid <= 1'b0;
		wait_drain();
		finish_test();

		$display("tests passed %0d, tests failed %0d, errors %0d", tests_passed, tests_failed,
			err_count);
		if (tests_failed == 0 && err_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: project.f
+incdir+include
src/div_pkg.sv
src/div_req_decode.sv
src/div_req_fifo.sv
src/div_core.sv
src/div_unit.sv
verification/div_clk_gen.sv
verification/div_unit_tb.sv

// File: verification/div_cases.txt
# columns are opcode, dividend, divisor and expected result, all in hex
# opcodes 0 to 7 are div divu rem remu divw divuw remw remuw
0 0000000000000014 0000000000000006 0000000000000003
0 FFFFFFFFFFFFFFEC 0000000000000006 FFFFFFFFFFFFFFFD
0 0000000000000014 FFFFFFFFFFFFFFFA FFFFFFFFFFFFFFFD
0 FFFFFFFFFFFFFFEC FFFFFFFFFFFFFFFA 0000000000000003
0 8000000000000000 0000000000000002 C000000000000000
1 0000000000000014 0000000000000006 0000000000000003
1 8000000000000000 0000000000000002 4000000000000000
1 FFFFFFFFFFFFFFFF 0000000000000010 0FFFFFFFFFFFFFFF
2 FFFFFFFFFFFFFFEC 0000000000000006 FFFFFFFFFFFFFFFE
2 0000000000000014 FFFFFFFFFFFFFFFA 0000000000000002
2 FFFFFFFFFFFFFFEC FFFFFFFFFFFFFFFA FFFFFFFFFFFFFFFE
3 FFFFFFFFFFFFFFEC 0000000000000006 0000000000000002
3 0000000000000064 0000000000000007 0000000000000002
3 7FFFFFFFFFFFFFFF 0000000000000010 000000000000000F
4 FFFFFFFFFFFFFFEC 0000000000000006 FFFFFFFFFFFFFFFD
4 1234567800000064 AAAAAAAAFFFFFFF6 FFFFFFFFFFFFFFF6
5 00000000FFFFFFEC 0000000000000006 000000002AAAAAA7
5 0000000080000000 0000000000000001 FFFFFFFF80000000
6 FFFFFFFFFFFFFFEC 0000000000000006 FFFFFFFFFFFFFFFE
6 0000000000000064 00000000FFFFFFF9 0000000000000002
7 00000000FFFFFFEC 0000000000000006 0000000000000002
7 FFFFFFFF80000005 0000000100000010 0000000000000005
